// File: src/nand_cpu_pkg.sv
package nand_cpu_pkg;

    localparam int word_w = 8;
    localparam int reg_count = 16;
    localparam int reg_addr_w = 4;

    typedef enum logic [2:0] {
        alu_cl,
        alu_cp,
        alu_nand,
        alu_ls,
        alu_rs,
        alu_eq,
        alu_ne,
        alu_li
    } alu_op_t;

    typedef enum logic {
        mem_read,
        mem_write
    } mem_op_t;

    // One instruction byte, register form or immediate form
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [reg_addr_w-1:0] rt;
        } reg_form;
        struct packed {
            logic [1:0] cls;        // 2'b10 is LI, 2'b11 with shift[1] set is INT/HLT
            logic [1:0] shift;
            logic [3:0] immdt;
        } imm_form;
    } instr_t;

    typedef struct packed {
        logic valid;
        logic use_ra;
        logic use_rt;
        logic [reg_addr_w-1:0] rt_addr;
        logic use_rw;
        logic [reg_addr_w-1:0] rw_addr;
        logic read_ps;
        logic write_ps;
        logic use_immdt;
        logic [3:0] immdt;
        logic [1:0] shift;
        logic mem_access;
        mem_op_t mem_op;
        logic jump;
        logic branch;
        logic interrupt;
        logic halt;
        alu_op_t alu_op;
    } decoded_t;

endpackage

// File: src/decoder.sv
module decoder (
    input logic valid,
    input nand_cpu_pkg::instr_t instr,
    output nand_cpu_pkg::decoded_t dec
);

    import nand_cpu_pkg::*;

    always_comb begin
        dec = '0;
        dec.valid = valid;
        dec.rt_addr = instr.reg_form.rt;
        dec.rw_addr = '0;                               // Accumulator unless CP or JRL
        dec.immdt = instr.imm_form.immdt;
        dec.shift = instr.imm_form.shift;
        dec.mem_op = mem_read;
        dec.alu_op = alu_cl;
        if (instr.imm_form.cls == 2'b10) begin           // LI
            dec.use_ra = 1'b1;
            dec.use_rw = 1'b1;
            dec.use_immdt = 1'b1;
            dec.alu_op = alu_li;
        end else if (instr.imm_form.cls == 2'b11 && instr.imm_form.shift[1]) begin
            dec.use_immdt = 1'b1;
            if (instr.imm_form.shift[0]) begin
                dec.halt = 1'b1;                         // HLT
            end else begin
                dec.interrupt = 1'b1;                    // INT
            end
        end else begin
            case (instr.reg_form.opcode)
                4'h0: begin
                    dec.use_rw = 1'b1;
                    if (instr.reg_form.rt == '0) begin
                        dec.alu_op = alu_cl;             // CL
                    end else begin
                        dec.use_ra = 1'b1;               // CP
                        dec.rw_addr = instr.reg_form.rt;
                        dec.alu_op = alu_cp;
                    end
                end
                4'h1: begin
                    dec.use_ra = 1'b1;
                    dec.use_rt = 1'b1;
                    dec.use_rw = 1'b1;
                    dec.alu_op = alu_nand;
                end
                4'h2: begin
                    dec.use_ra = 1'b1;
                    dec.use_rt = 1'b1;
                    dec.use_rw = 1'b1;
                    dec.alu_op = alu_ls;
                end
                4'h3: begin
                    dec.use_ra = 1'b1;
                    dec.use_rt = 1'b1;
                    dec.use_rw = 1'b1;
                    dec.alu_op = alu_rs;
                end
                4'h4: begin
                    dec.use_ra = 1'b1;
                    dec.use_rt = 1'b1;
                    dec.write_ps = 1'b1;
                    dec.alu_op = alu_eq;
                end
                4'h5: begin
                    dec.use_ra = 1'b1;
                    dec.use_rt = 1'b1;
                    dec.write_ps = 1'b1;
                    dec.alu_op = alu_ne;
                end
                4'h6: begin
                    dec.use_rt = 1'b1;                   // BR
                    dec.read_ps = 1'b1;
                    dec.branch = 1'b1;
                end
                4'h7: begin
                    dec.use_rt = 1'b1;                   // JRL
                    dec.use_rw = 1'b1;
                    dec.rw_addr = instr.reg_form.rt;
                    dec.jump = 1'b1;
                end
                4'hc: begin
                    dec.use_rt = 1'b1;                   // LD
                    dec.use_rw = 1'b1;
                    dec.mem_access = 1'b1;
                    dec.mem_op = mem_read;
                end
                4'hd: begin
                    dec.use_ra = 1'b1;                   // ST
                    dec.use_rt = 1'b1;
                    dec.mem_access = 1'b1;
                    dec.mem_op = mem_write;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        if (dec.valid) begin
            assert ($onehot0({dec.jump, dec.branch, dec.mem_access, dec.interrupt, dec.halt}))
                else $error("decoder: conflicting control for instr %h", instr);
        end
    end

endmodule

// File: src/regfile.sv
module regfile (
    input logic clk,
    input logic reset,
    input nand_cpu_pkg::decoded_t dec,
    input logic [nand_cpu_pkg::word_w-1:0] alu_result,
    input logic alu_ps,
    input logic [nand_cpu_pkg::word_w-1:0] mem_rdata,
    input logic [nand_cpu_pkg::word_w-1:0] link,
    output logic [nand_cpu_pkg::word_w-1:0] ra_value,
    output logic [nand_cpu_pkg::word_w-1:0] rt_value,
    output logic ps
);

    import nand_cpu_pkg::*;

    logic [reg_count-1:0][word_w-1:0] regs;
    logic [word_w-1:0] wb_data;

    always_comb begin
        if (dec.mem_access) begin
            wb_data = mem_rdata;                         // LD
        end else if (dec.jump) begin
            wb_data = link;                              // JRL return address
        end else begin
            wb_data = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
            ps <= 1'b0;
        end else if (dec.valid) begin
            if (dec.use_rw) begin
                regs[dec.rw_addr] <= wb_data;
            end
            if (dec.write_ps) begin
                ps <= alu_ps;
            end
        end
    end

    assign ra_value = regs[0];
    assign rt_value = regs[dec.rt_addr];

    // Architectural state frozen while halted
    assert property (@(posedge clk) disable iff (reset)
        !dec.valid |=> $stable(regs) && $stable(ps))
        else $error("regfile: state changed without a valid instruction");

endmodule

// File: src/alu.sv
module alu (
    input nand_cpu_pkg::decoded_t dec,
    input logic [nand_cpu_pkg::word_w-1:0] ra_value,
    input logic [nand_cpu_pkg::word_w-1:0] rt_value,
    output logic [nand_cpu_pkg::word_w-1:0] result,
    output logic ps_out
);

    import nand_cpu_pkg::*;

    logic [2:0] shamt;
    logic [word_w-1:0] imm_value;

    assign shamt = rt_value[2:0];                        // Shift distance 0 to 7

    // Immediate placed 0 to 3 bits up, top bits dropped
    assign imm_value = word_w'(dec.immdt) << dec.shift;

    always_comb begin
        result = '0;
        ps_out = 1'b0;
        case (dec.alu_op)
            alu_cl: begin
                result = '0;
            end
            alu_cp: begin
                result = ra_value;                       // r0 into rt
            end
            alu_nand: begin
                result = ~(ra_value & rt_value);
            end
            alu_ls: begin
                result = ra_value << shamt;
            end
            alu_rs: begin
                result = ra_value >> shamt;
            end
            alu_eq: begin
                ps_out = (ra_value == rt_value);
            end
            alu_ne: begin
                ps_out = (ra_value != rt_value);
            end
            alu_li: begin
                result = imm_value;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: src/fetch_unit.sv
module fetch_unit (
    input logic clk,
    input logic reset,
    input nand_cpu_pkg::decoded_t dec,
    input logic [nand_cpu_pkg::word_w-1:0] rt_value,
    input logic ps,
    output logic [nand_cpu_pkg::word_w-1:0] pc,
    output logic [nand_cpu_pkg::word_w-1:0] link,
    output logic valid,
    output logic halted,
    output logic int_valid,
    output logic [3:0] int_code
);

    import nand_cpu_pkg::*;

    logic taken;
    logic [word_w-1:0] next_pc;

    assign valid = !halted && !reset;
    assign link = pc + word_w'(1);
    assign taken = dec.jump || (dec.branch && dec.read_ps && ps);

    always_comb begin
        if (dec.halt) begin
            next_pc = pc;                                // Park on the HLT word
        end else if (taken) begin
            next_pc = rt_value;
        end else begin
            next_pc = link;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            halted <= 1'b0;
            int_valid <= 1'b0;
        end else begin
            int_valid <= dec.valid && dec.interrupt;     // Single cycle pulse
            if (dec.valid) begin
                pc <= next_pc;
                if (dec.halt) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid && dec.interrupt) begin
            int_code <= dec.immdt;
        end
    end

    assert property (@(posedge clk) disable iff (reset) halted |=> $stable(pc))
        else $error("fetch_unit: pc moved while halted");

endmodule

// File: src/nand_cpu.sv
module nand_cpu (
    input logic clk,
    input logic reset,
    output logic [nand_cpu_pkg::word_w-1:0] imem_addr,
    input logic [nand_cpu_pkg::word_w-1:0] imem_data,
    output logic [nand_cpu_pkg::word_w-1:0] dmem_addr,
    output logic [nand_cpu_pkg::word_w-1:0] dmem_wdata,
    output logic dmem_we,
    input logic [nand_cpu_pkg::word_w-1:0] dmem_rdata,
    output logic int_valid,
    output logic [3:0] int_code,
    output logic halted
);

    import nand_cpu_pkg::*;

    instr_t instr;
    decoded_t dec;
    logic valid;
    logic ps;
    logic alu_ps;
    logic [word_w-1:0] ra_value;
    logic [word_w-1:0] rt_value;
    logic [word_w-1:0] alu_result;
    logic [word_w-1:0] pc;
    logic [word_w-1:0] link;

    assign instr = imem_data;
    assign imem_addr = pc;
    assign dmem_addr = rt_value;
    assign dmem_wdata = ra_value;                        // ST writes r0
    assign dmem_we = dec.valid && dec.mem_access && (dec.mem_op == mem_write);

    decoder decoder_i (
        .valid(valid),
        .instr(instr),
        .dec(dec)
    );

    regfile regfile_i (
        .clk(clk),
        .reset(reset),
        .dec(dec),
        .alu_result(alu_result),
        .alu_ps(alu_ps),
        .mem_rdata(dmem_rdata),
        .link(link),
        .ra_value(ra_value),
        .rt_value(rt_value),
        .ps(ps)
    );

    alu alu_i (
        .dec(dec),
        .ra_value(ra_value),
        .rt_value(rt_value),
        .result(alu_result),
        .ps_out(alu_ps)
    );

    fetch_unit fetch_unit_i (
        .clk(clk),
        .reset(reset),
        .dec(dec),
        .rt_value(rt_value),
        .ps(ps),
        .pc(pc),
        .link(link),
        .valid(valid),
        .halted(halted),
        .int_valid(int_valid),
        .int_code(int_code)
    );

endmodule

// File: bench/nand_cpu_tb.sv
module nand_cpu_tb;

    import nand_cpu_pkg::*;

    localparam logic [3:0] op_cl = 4'h0;
    localparam logic [3:0] op_nnd = 4'h1;
    localparam logic [3:0] op_ls = 4'h2;
    localparam logic [3:0] op_rs = 4'h3;
    localparam logic [3:0] op_eq = 4'h4;
    localparam logic [3:0] op_ne = 4'h5;
    localparam logic [3:0] op_br = 4'h6;
    localparam logic [3:0] op_jrl = 4'h7;
    localparam logic [3:0] op_ld = 4'hc;
    localparam logic [3:0] op_st = 4'hd;

    logic clk = 1'b0;
    logic reset;
    logic [7:0] imem_addr;
    logic [7:0] imem_data;
    logic [7:0] dmem_addr;
    logic [7:0] dmem_wdata;
    logic dmem_we;
    logic [7:0] dmem_rdata;
    logic int_valid;
    logic [3:0] int_code;
    logic halted;

    logic [7:0] rom [256];
    logic [7:0] ram [256];
    logic [7:0] ram_init [256];
    logic [7:0] prog_ptr;
    int value_errors;
    int other_errors;

    // Instruction-set model state
    logic [7:0] m_regs [16];
    logic [7:0] m_ram [256];
    logic [7:0] m_pc;
    logic m_ps;
    logic m_halted;
    logic m_int_valid;
    logic [3:0] m_int_code;
    logic [7:0] m_instr;
    logic exp_st;
    logic exp_ld;
    logic [7:0] exp_addr;
    logic [7:0] exp_wdata;

    always #5 clk = ~clk;

    nand_cpu dut_i (
        .clk(clk),
        .reset(reset),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata),
        .int_valid(int_valid),
        .int_code(int_code),
        .halted(halted)
    );

    assign imem_data = rom[imem_addr];
    assign dmem_rdata = ram[dmem_addr];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                ram[i] <= ram_init[i];
            end
        end else if (dmem_we) begin
            ram[dmem_addr] <= dmem_wdata;
        end
    end

    assign m_instr = rom[m_pc];
    assign exp_st = !reset && !m_halted && (m_instr[7:4] == op_st);
    assign exp_ld = !reset && !m_halted && (m_instr[7:4] == op_ld);
    assign exp_addr = m_regs[m_instr[3:0]];
    assign exp_wdata = m_regs[0];

    function automatic logic [7:0] li_word(input logic [1:0] sh, input logic [3:0] imm);
        return {2'b10, sh, imm};
    endfunction

    function automatic logic [7:0] reg_word(input logic [3:0] op, input logic [3:0] rt);
        return {op, rt};
    endfunction

    function automatic logic [3:0] rand_nib();
        logic [31:0] r;
        r = $urandom;
        return r[3:0];
    endfunction

    task automatic emit(input logic [7:0] w);
        rom[prog_ptr] = w;
        prog_ptr = prog_ptr + 8'd1;
    endtask

    task automatic report_value(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
        value_errors++;
    endtask

    task automatic step_model();
        logic [7:0] w;
        logic [3:0] rt;
        logic [7:0] rt_val;
        logic [7:0] next_pc;
        w = rom[m_pc];
        rt = w[3:0];
        rt_val = m_regs[rt];
        next_pc = m_pc + 8'd1;
        if (w[7:6] == 2'b10) begin
            m_regs[0] = {4'b0, w[3:0]} << w[5:4];    // LI, overflow dropped
        end else if (w[7:5] == 3'b111) begin
            if (w[4]) begin
                m_halted = 1'b1;
                next_pc = m_pc;
            end else begin
                m_int_valid = 1'b1;
                m_int_code = w[3:0];
            end
        end else begin
            case (w[7:4])
                op_cl: begin
                    if (rt == 4'h0) begin
                        m_regs[0] = 8'h00;
                    end else begin
                        m_regs[rt] = m_regs[0];
                    end
                end
                op_nnd: m_regs[0] = ~(m_regs[0] & rt_val);
                op_ls: m_regs[0] = m_regs[0] << rt_val[2:0];
                op_rs: m_regs[0] = m_regs[0] >> rt_val[2:0];
                op_eq: m_ps = (m_regs[0] == rt_val);
                op_ne: m_ps = (m_regs[0] != rt_val);
                op_br: begin
                    if (m_ps) begin
                        next_pc = rt_val;
                    end
                end
                op_jrl: begin
                    m_regs[rt] = m_pc + 8'd1;
                    next_pc = rt_val;                 // Target read before link write
                end
                op_ld: m_regs[0] = m_ram[rt_val];
                op_st: m_ram[rt_val] = m_regs[0];
                default: begin
                end
            endcase
        end
        m_pc = next_pc;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                m_regs[i] = 8'h00;
            end
            for (int i = 0; i < 256; i++) begin
                m_ram[i] = ram_init[i];
            end
            m_pc = 8'h00;
            m_ps = 1'b0;
            m_halted = 1'b0;
            m_int_valid = 1'b0;
            m_int_code = 4'h0;
        end else begin
            m_int_valid = 1'b0;
            if (!m_halted) begin
                step_model();
            end
        end
    end

    // Checked on the falling edge, where DUT and model are settled
    assert property (@(negedge clk) disable iff (reset) imem_addr == m_pc)
        else report_value("imem_addr", imem_addr, m_pc);
    assert property (@(negedge clk) dmem_we == exp_st)
        else report_value("dmem_we", {7'b0, dmem_we}, {7'b0, exp_st});
    assert property (@(negedge clk) (exp_st || exp_ld) |-> dmem_addr == exp_addr)
        else report_value("dmem_addr", dmem_addr, exp_addr);
    assert property (@(negedge clk) exp_st |-> dmem_wdata == exp_wdata)
        else report_value("dmem_wdata", dmem_wdata, exp_wdata);
    assert property (@(negedge clk) halted == m_halted)
        else report_value("halted", {7'b0, halted}, {7'b0, m_halted});
    assert property (@(negedge clk) int_valid == m_int_valid)
        else report_value("int_valid", {7'b0, int_valid}, {7'b0, m_int_valid});
    assert property (@(negedge clk) m_int_valid |-> int_code == m_int_code)
        else report_value("int_code", {4'b0, int_code}, {4'b0, m_int_code});

    initial begin
        logic [31:0] rnd;
        logic [7:0] addr;
        logic [3:0] a_val;
        logic [3:0] b_val;
        int wait_cycles;
        reset = 1'b1;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(32'hfa04));
        for (int i = 0; i < 256; i++) begin
            addr = i[7:0];
            rnd = $urandom;
            ram_init[addr] = rnd[7:0];
            rom[addr] = {4'hf, addr[7:4] ^ addr[3:0]};   // HLT fill
        end
        a_val = rand_nib();
        b_val = a_val ^ 4'h1;

        // Arithmetic, shifts and stores
        prog_ptr = 8'h00;
        emit(li_word(2'd2, rand_nib()));
        emit(reg_word(op_cl, 4'd2));
        emit(li_word(2'd0, rand_nib()));
        emit(reg_word(op_cl, 4'd3));
        emit(li_word(2'd1, 4'd4));
        emit(reg_word(op_cl, 4'd1));
        emit(li_word(2'd3, rand_nib()));
        emit(reg_word(op_st, 4'd1));
        emit(li_word(2'd0, rand_nib()));
        emit(reg_word(op_cl, 4'd4));
        emit(li_word(2'd3, rand_nib()));
        emit(reg_word(op_nnd, 4'd2));
        emit(reg_word(op_st, 4'd3));
        emit(reg_word(op_ls, 4'd4));
        emit(reg_word(op_st, 4'd1));
        emit(reg_word(op_rs, 4'd4));
        emit(reg_word(op_st, 4'd2));
        emit(reg_word(op_cl, 4'd0));
        emit(reg_word(op_st, 4'd1));
        // Compare and branch
        emit(li_word(2'd2, 4'd8));                      // 0x20
        emit(reg_word(op_cl, 4'd5));
        emit(li_word(2'd0, a_val));
        emit(reg_word(op_cl, 4'd6));
        emit(reg_word(op_eq, 4'd6));
        emit(reg_word(op_br, 4'd5));
        prog_ptr = 8'h20;
        emit(li_word(2'd2, 4'd10));                     // 0x28
        emit(reg_word(op_cl, 4'd5));
        emit(li_word(2'd0, b_val));
        emit(reg_word(op_eq, 4'd6));
        emit(reg_word(op_br, 4'd5));
        emit(reg_word(op_ne, 4'd6));
        emit(reg_word(op_br, 4'd5));
        prog_ptr = 8'h28;
        emit(li_word(2'd2, 4'd12));
        emit(reg_word(op_cl, 4'd5));
        emit(li_word(2'd0, a_val));
        emit(reg_word(op_ne, 4'd6));
        emit(reg_word(op_br, 4'd5));
        emit(li_word(2'd2, 4'd14));                     // 0x38
        emit(reg_word(op_cl, 4'd7));
        emit(reg_word(op_jrl, 4'd7));
        // Link store, load and copy, interrupt, halt
        prog_ptr = 8'h38;
        emit(li_word(2'd1, 4'd10));
        emit(reg_word(op_cl, 4'd8));
        emit(reg_word(op_st, 4'd7));
        emit(reg_word(op_ld, 4'd8));
        emit(reg_word(op_st, 4'd1));
        emit(reg_word(op_ld, 4'd3));
        emit(reg_word(op_st, 4'd8));
        emit({4'he, rand_nib()});
        emit(8'hf0);

        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        wait_cycles = 0;
        while (!halted && wait_cycles < 2000) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!halted) begin
            $display("Timeout: CPU did not halt within 2000 cycles");
            other_errors++;
        end else begin
            for (int i = 0; i < 10; i++) begin
                @(negedge clk);                         // Watch the parked pc
            end
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
src/nand_cpu_pkg.sv
src/decoder.sv
src/regfile.sv
src/alu.sv
src/fetch_unit.sv
src/nand_cpu.sv
bench/nand_cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= nand_cpu_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= TEST OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
